// ==== verilog/sieve_pkg.sv ====
`default_nettype none

package sieve_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int data_w   = 32;
    localparam int seq_id_w = 8;
    localparam int dest_w   = 6;

    typedef enum logic {
        seq_running = 1'b0,
        seq_done    = 1'b1
    } seq_state_t;

    // --------------------
    // Packets
    // --------------------
    // 53-bit payload
    typedef struct packed {
        logic [data_w-1:0]   data;
        logic [dest_w-1:0]   destination;
        logic [dest_w-1:0]   source;
        seq_state_t          state;
        logic [seq_id_w-1:0] id;
    } engine_payload_t;

    typedef struct packed {
        logic            valid;
        engine_payload_t payload;
    } engine_packet_t;

    // Threshold and result destination
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] threshold;
        logic [dest_w-1:0] destination;
    } sieve_config_t;

    typedef struct packed {
        logic empty;
        logic prog_full;
    } fifo_status_t;

    // --------------------
    // Control FSM
    // --------------------
    typedef enum logic [3:0] {
        ctrl_reset,
        ctrl_idle,
        ctrl_setup_idle,
        ctrl_setup_trans,
        ctrl_setup,
        ctrl_start_trans,
        ctrl_start,
        ctrl_busy,
        ctrl_pause_trans,
        ctrl_pause,
        ctrl_busy_trans
    } control_state_t;

endpackage : sieve_pkg

`default_nettype wire

// ==== verilog/packet_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_fifo #(
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 8
) (
    input  wire logic                       ap_clk,
    input  wire logic                       areset_generator,
    input  wire sieve_pkg::engine_payload_t din,
    input  wire logic                       wr_en,
    input  wire logic                       rd_en,
    output sieve_pkg::engine_payload_t      dout,
    output logic                            valid,
    output logic                            empty,
    output logic                            prog_full
);

    import sieve_pkg::*;

    localparam int addr_w  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int count_w = $clog2(fifo_depth + 1);

    engine_payload_t    mem [fifo_depth];
    logic [addr_w-1:0]  wr_ptr;
    logic [addr_w-1:0]  rd_ptr;
    logic [count_w-1:0] count;
    logic               full;
    logic               do_wr;
    logic               do_rd;

    // Pointer wrap for any depth
    function automatic logic [addr_w-1:0] next_ptr(input logic [addr_w-1:0] ptr);
        if (ptr == addr_w'(fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == count_w'(fifo_depth));
    assign empty     = (count == '0);
    assign prog_full = (count >= count_w'(prog_thresh));

    assign do_rd = rd_en & ~empty;
    // A write into a full FIFO is allowed when a read frees the slot
    assign do_wr = wr_en & (~full | do_rd);

    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= do_rd;
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : packet_fifo

`default_nettype wire

// ==== verilog/sieve_control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module sieve_control_fsm (
    input  wire logic                     ap_clk,
    input  wire logic                     areset_generator,
    input  wire logic                     descriptor_valid,
    input  wire logic                     rd_en_seen,
    input  wire sieve_pkg::sieve_config_t config_in,
    input  wire logic                     out_prog_full,
    output logic                          config_setup,
    output sieve_pkg::sieve_config_t      active_config,
    output sieve_pkg::control_state_t     state,
    output logic                          started
);

    import sieve_pkg::*;

    control_state_t    next_state;
    logic              cfg_valid;
    logic [data_w-1:0] cfg_threshold;
    logic [dest_w-1:0] cfg_destination;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= ctrl_reset;
        end else begin
            state <= next_state;
        end
    end

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            ctrl_reset:       next_state = ctrl_idle;
            ctrl_idle: begin
                if (descriptor_valid) begin
                    next_state = ctrl_setup_idle;
                end
            end
            // Config request goes out once the consumer is reading
            ctrl_setup_idle: begin
                if (rd_en_seen) begin
                    next_state = ctrl_setup_trans;
                end
            end
            ctrl_setup_trans: next_state = ctrl_setup;
            ctrl_setup: begin
                if (config_in.valid) begin
                    next_state = ctrl_start_trans;
                end
            end
            ctrl_start_trans: next_state = ctrl_start;
            ctrl_start:       next_state = ctrl_busy;
            ctrl_busy: begin
                if (out_prog_full) begin
                    next_state = ctrl_pause_trans;
                end
            end
            ctrl_pause_trans: next_state = ctrl_pause;
            ctrl_pause: begin
                if (!out_prog_full) begin
                    next_state = ctrl_busy_trans;
                end
            end
            ctrl_busy_trans:  next_state = ctrl_busy;
            default:          next_state = ctrl_reset;
        endcase
    end

    // --------------------
    // Control flags
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_setup <= 1'b0;
            cfg_valid    <= 1'b0;
            started      <= 1'b0;
        end else begin
            // One-cycle request on entry to setup
            config_setup <= (state == ctrl_setup_trans);
            if (state == ctrl_setup) begin
                cfg_valid <= 1'b0;
            end else if (state == ctrl_start_trans) begin
                cfg_valid <= 1'b1;
            end
            // Sticky from the start state on
            if (state == ctrl_start_trans) begin
                started <= 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if ((state == ctrl_setup) && config_in.valid) begin
            cfg_threshold   <= config_in.threshold;
            cfg_destination <= config_in.destination;
        end
    end

    assign active_config = '{
        valid:       cfg_valid,
        threshold:   cfg_threshold,
        destination: cfg_destination
    };

endmodule : sieve_control_fsm

`default_nettype wire

// ==== verilog/sequence_hold_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sequence_hold_timer #(
    parameter int hold_cycles = 2
) (
    input  wire logic ap_clk,
    input  wire logic areset_generator,
    input  wire logic seq_end,
    output logic      hold
);

    localparam int count_w = (hold_cycles > 0) ? $clog2(hold_cycles + 1) : 1;

    logic [count_w-1:0] count;

    // Reload on every sequence end, then count down to zero
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count <= '0;
        end else if (seq_end) begin
            count <= count_w'(hold_cycles);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Block pops in the end cycle itself too, before the count is loaded
    assign hold = seq_end | (count != '0);

endmodule : sequence_hold_timer

`default_nettype wire

// ==== verilog/sieve_kernel.sv ====
`timescale 1ns/1ps
`default_nettype none

module sieve_kernel (
    input  wire logic                         ap_clk,
    input  wire logic                         areset_generator,
    input  wire logic                         clear,
    input  wire logic [sieve_pkg::data_w-1:0] threshold,
    input  wire logic                         data_valid,
    input  wire logic [sieve_pkg::data_w-1:0] data,
    input  wire logic                         seq_end,
    output logic                              result_valid,
    output logic [sieve_pkg::data_w-1:0]      result
);

    import sieve_pkg::*;

    logic              s1_valid;
    logic              s1_end;
    logic [data_w-1:0] s1_value;
    logic [data_w-1:0] acc;
    logic [data_w-1:0] acc_next;
    logic              s2_valid;
    logic [data_w-1:0] s2_sum;

    // --------------------
    // Stage 1 threshold
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
            s1_end   <= 1'b0;
        end else begin
            s1_valid <= data_valid;
            s1_end   <= data_valid & seq_end;
        end
    end

    // Values below the threshold contribute nothing
    always_ff @(posedge ap_clk) begin
        s1_value <= (data >= threshold) ? data : '0;
    end

    // --------------------
    // Stage 2 accumulate
    // --------------------
    // wraps at data_w
    assign acc_next = acc + s1_value;

    always_ff @(posedge ap_clk) begin
        if (areset_generator || clear) begin
            acc      <= '0;
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_end;
            if (s1_valid) begin
                // Closing value is in acc_next, start fresh after it
                acc <= s1_end ? '0 : acc_next;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        s2_sum <= acc_next;
    end

    // --------------------
    // Stage 3 result
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= s2_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        result <= s2_sum;
    end

endmodule : sieve_kernel

`default_nettype wire

// ==== verilog/result_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_pipeline (
    input  wire logic                         ap_clk,
    input  wire sieve_pkg::engine_packet_t    packet_in,
    input  wire logic [sieve_pkg::dest_w-1:0] destination,
    input  wire logic                         result_valid,
    input  wire logic [sieve_pkg::data_w-1:0] result,
    output sieve_pkg::engine_packet_t         packet_out
);

    import sieve_pkg::*;

    // Matches the kernel latency
    localparam int stages = 3;

    engine_packet_t stage [stages];
    logic           closing;

    // --------------------
    // Delay line
    // --------------------
    always_ff @(posedge ap_clk) begin
        stage[0]                     <= packet_in;
        stage[0].payload.destination <= destination;
        for (int i = 1; i < stages; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    // Only closing packets that line up with a kernel result leave
    assign closing = stage[stages-1].valid
                   & (stage[stages-1].payload.state == seq_done)
                   & result_valid;

    // --------------------
    // Merge stage
    // --------------------
    always_ff @(posedge ap_clk) begin
        packet_out.valid        <= closing;
        packet_out.payload      <= stage[stages-1].payload;
        packet_out.payload.data <= result;
    end

endmodule : result_pipeline

`default_nettype wire

// ==== verilog/sieve_engine_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sieve_engine_top #(
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 8,
    parameter int hold_cycles = 2
) (
    input  wire logic                      ap_clk,
    input  wire logic                      areset_generator,
    input  wire logic                      descriptor_valid,
    output logic                           config_setup,
    input  wire sieve_pkg::sieve_config_t  config_in,
    input  wire sieve_pkg::engine_packet_t response_in,
    input  wire logic                      response_rd_en,
    output sieve_pkg::fifo_status_t        response_fifo_status,
    output sieve_pkg::engine_packet_t      request_out,
    input  wire logic                      request_ready,
    output logic                           done
);

    import sieve_pkg::*;

    logic            descriptor_reg;
    sieve_config_t   config_reg;
    engine_packet_t  response_reg;
    logic            rd_en_reg;
    logic            ready_reg;

    engine_payload_t in_dout;
    logic            in_rd_en;
    logic            in_valid;
    logic            in_empty;
    logic            in_prog_full;

    engine_payload_t out_dout;
    logic            out_rd_en;
    logic            out_valid;
    logic            out_empty;
    logic            out_prog_full;

    sieve_config_t     active_config;
    control_state_t    state;
    logic              started;
    logic              hold;
    engine_packet_t    popped;
    logic              popped_end;
    logic              result_valid;
    logic [data_w-1:0] result;
    engine_packet_t    pipe_out;

    // --------------------
    // Input registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        config_reg   <= config_in;
        response_reg <= response_in;
        if (areset_generator) begin
            descriptor_reg     <= 1'b0;
            config_reg.valid   <= 1'b0;
            response_reg.valid <= 1'b0;
            rd_en_reg          <= 1'b0;
            ready_reg          <= 1'b0;
        end else begin
            descriptor_reg <= descriptor_valid;
            rd_en_reg      <= response_rd_en;
            ready_reg      <= request_ready;
        end
    end

    // --------------------
    // Output registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        request_out.payload <= out_dout;
        if (areset_generator) begin
            request_out.valid <= 1'b0;
            done              <= 1'b0;
        end else begin
            request_out.valid <= out_valid;
            done              <= started & in_empty & out_empty;
        end
    end

    assign response_fifo_status = '{empty: in_empty, prog_full: in_prog_full};

    // Pop only while busy, with room downstream and no hold pending
    assign in_rd_en = ~in_empty & rd_en_reg & ~out_prog_full & (state == ctrl_busy) & ~hold;
    assign out_rd_en = ~out_empty & ready_reg;

    assign popped     = '{valid: in_valid, payload: in_dout};
    assign popped_end = in_valid & (in_dout.state == seq_done);

    packet_fifo #(
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) u_input_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .din             (response_reg.payload),
        .wr_en           (response_reg.valid),
        .rd_en           (in_rd_en),
        .dout            (in_dout),
        .valid           (in_valid),
        .empty           (in_empty),
        .prog_full       (in_prog_full)
    );

    sieve_control_fsm u_control (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .descriptor_valid(descriptor_reg),
        .rd_en_seen      (rd_en_reg),
        .config_in       (config_reg),
        .out_prog_full   (out_prog_full),
        .config_setup    (config_setup),
        .active_config   (active_config),
        .state           (state),
        .started         (started)
    );

    sequence_hold_timer #(
        .hold_cycles(hold_cycles)
    ) u_hold_timer (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .seq_end         (popped_end),
        .hold            (hold)
    );

    sieve_kernel u_kernel (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .clear           (~active_config.valid),
        .threshold       (active_config.threshold),
        .data_valid      (in_valid),
        .data            (in_dout.data),
        .seq_end         (popped_end),
        .result_valid    (result_valid),
        .result          (result)
    );

    result_pipeline u_result_pipeline (
        .ap_clk      (ap_clk),
        .packet_in   (popped),
        .destination (active_config.destination),
        .result_valid(result_valid),
        .result      (result),
        .packet_out  (pipe_out)
    );

    packet_fifo #(
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) u_output_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .din             (pipe_out.payload),
        .wr_en           (pipe_out.valid),
        .rd_en           (out_rd_en),
        .dout            (out_dout),
        .valid           (out_valid),
        .empty           (out_empty),
        .prog_full       (out_prog_full)
    );

endmodule : sieve_engine_top

`default_nettype wire

// ==== sim/sieve_engine_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sieve_engine_tb;

    import sieve_pkg::*;

    typedef engine_payload_t payload_q_t[$];

    localparam int          wait_limit  = 5000;
    localparam logic [31:0] threshold   = 32'h4000_0000;
    localparam logic [5:0]  result_dest = 6'h2a;

    logic           ap_clk;
    logic           areset_generator;
    logic           descriptor_valid;
    logic           config_setup;
    sieve_config_t  config_in;
    engine_packet_t response_in;
    logic           response_rd_en;
    fifo_status_t   response_fifo_status;
    engine_packet_t request_out;
    logic           request_ready;
    logic           done;

    sieve_config_t test_config;
    payload_q_t    sent;
    payload_q_t    expected;
    int            rx_count      = 0;
    int            seq_count     = 0;
    int            setup_pulses  = 0;
    int            error_count   = 0;
    int            timeout_count = 0;
    logic [31:0]   lfsr_state    = 32'd1;

    sieve_engine_top #(
        .fifo_depth (16),
        .prog_thresh(8),
        .hold_cycles(2)
    ) uut (
        .ap_clk              (ap_clk),
        .areset_generator    (areset_generator),
        .descriptor_valid    (descriptor_valid),
        .config_setup        (config_setup),
        .config_in           (config_in),
        .response_in         (response_in),
        .response_rd_en      (response_rd_en),
        .response_fifo_status(response_fifo_status),
        .request_out         (request_out),
        .request_ready       (request_ready),
        .done                (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    // --------------------
    // Random source
    // --------------------
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'hd000_0001;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_step()};
        end
        return value;
    endfunction

    // Thresholded sum per sequence including the closing packet
    function automatic payload_q_t expected_results(input payload_q_t    pkts,
                                                    input sieve_config_t cfg);
        payload_q_t      results;
        engine_payload_t r;
        logic [31:0]     sum;
        sum = '0;
        foreach (pkts[i]) begin
            if (pkts[i].data >= cfg.threshold) begin
                sum = sum + pkts[i].data;
            end
            if (pkts[i].state == seq_done) begin
                r             = pkts[i];
                r.data        = sum;
                r.destination = cfg.destination;
                results.push_back(r);
                sum = '0;
            end
        end
        return results;
    endfunction

    // --------------------
    // Reporting
    // --------------------
    task automatic finish_run();
        $display("summary: %0d errors, %0d timeouts, %0d of %0d results received",
                 error_count, timeout_count, rx_count, expected.size());
        if (error_count == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout at %0t: %s within %0d cycles", $time, what, wait_limit);
        finish_run();
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            error_count++;
            $display("error at %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // --------------------
    // Waits
    // --------------------
    task automatic wait_for_setup();
        int waited;
        waited = 0;
        @(negedge ap_clk);
        while (!config_setup) begin
            waited++;
            if (waited > wait_limit) report_timeout("config_setup did not pulse");
            @(negedge ap_clk);
        end
    endtask

    task automatic wait_for_input_full();
        int waited;
        waited = 0;
        @(negedge ap_clk);
        while (!response_fifo_status.prog_full) begin
            waited++;
            if (waited > wait_limit) report_timeout("input FIFO never reached prog_full");
            @(negedge ap_clk);
        end
    endtask

    task automatic wait_for_results(input string phase);
        int waited;
        waited = 0;
        @(negedge ap_clk);
        while (rx_count < expected.size()) begin
            waited++;
            if (waited > wait_limit) report_timeout({phase, " results did not all arrive"});
            @(negedge ap_clk);
        end
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        @(negedge ap_clk);
        while (!done) begin
            waited++;
            if (waited > wait_limit) report_timeout("done did not rise after the drain");
            @(negedge ap_clk);
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge ap_clk);
            response_in.valid <= 1'b0;
        end
    endtask

    // Producer side honors prog_full
    task automatic send_packet(input engine_payload_t p);
        int waited;
        waited = 0;
        @(negedge ap_clk);
        while (response_fifo_status.prog_full) begin
            waited++;
            if (waited > wait_limit) report_timeout("input FIFO prog_full did not clear");
            @(posedge ap_clk);
            response_in.valid <= 1'b0;
            @(negedge ap_clk);
        end
        @(posedge ap_clk);
        response_in <= '{valid: 1'b1, payload: p};
    endtask

    task automatic send_sequence(input int len, input logic near_threshold, input logic gaps);
        payload_q_t      seq;
        engine_payload_t p;
        for (int i = 0; i < len; i++) begin
            p.data        = near_threshold ? threshold - 32'd2 + random_bits(2) : random_bits(32);
            p.destination = 6'(random_bits(6));
            p.source      = 6'(random_bits(6));
            p.state       = (i == len - 1) ? seq_done : seq_running;
            p.id          = 8'(seq_count);
            seq.push_back(p);
        end
        seq_count++;
        foreach (seq[i]) begin
            sent.push_back(seq[i]);
        end
        expected = expected_results(sent, test_config);
        foreach (seq[i]) begin
            send_packet(seq[i]);
            if (gaps && random_bits(2) == 32'd0) begin
                idle_cycles(1 + int'(random_bits(1)));
            end
        end
    endtask

    // --------------------
    // Monitors
    // --------------------
    always @(negedge ap_clk) begin
        if (!areset_generator && config_setup) begin
            setup_pulses++;
        end
    end

    always @(negedge ap_clk) begin
        if (!areset_generator && request_out.valid) begin
            assert (rx_count < expected.size()) else begin
                error_count++;
                $display("error at %0t: result packet with no sequence pending", $time);
            end
            if (rx_count < expected.size()) begin
                check_value($sformatf("result %0d data", rx_count),
                            request_out.payload.data, expected[rx_count].data);
                check_value($sformatf("result %0d destination", rx_count),
                            32'(request_out.payload.destination),
                            32'(expected[rx_count].destination));
                check_value($sformatf("result %0d source", rx_count),
                            32'(request_out.payload.source), 32'(expected[rx_count].source));
                check_value($sformatf("result %0d state", rx_count),
                            32'(request_out.payload.state), 32'(expected[rx_count].state));
                check_value($sformatf("result %0d id", rx_count),
                            32'(request_out.payload.id), 32'(expected[rx_count].id));
            end
            rx_count++;
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        areset_generator = 1'b1;
        descriptor_valid = 1'b0;
        config_in        = '0;
        response_in      = '0;
        response_rd_en   = 1'b0;
        request_ready    = 1'b0;
        test_config      = '{valid: 1'b1, threshold: threshold, destination: result_dest};

        repeat (16) @(posedge ap_clk);
        areset_generator <= 1'b0;
        @(negedge ap_clk);
        check_value("done after reset", 32'(done), 32'd0);
        check_value("config_setup after reset", 32'(config_setup), 32'd0);
        check_value("request_out.valid after reset", 32'(request_out.valid), 32'd0);
        check_value("input FIFO empty after reset", 32'(response_fifo_status.empty), 32'd1);
        check_value("input FIFO prog_full after reset",
                    32'(response_fifo_status.prog_full), 32'd0);

        // Start, then the config request
        @(posedge ap_clk);
        descriptor_valid <= 1'b1;
        response_rd_en   <= 1'b1;
        request_ready    <= 1'b1;
        @(posedge ap_clk);
        descriptor_valid <= 1'b0;
        wait_for_setup();
        repeat (8) @(negedge ap_clk);
        check_value("config_setup pulses before config", setup_pulses, 32'd1);
        @(posedge ap_clk);
        config_in <= test_config;
        @(posedge ap_clk);
        config_in.valid <= 1'b0;

        // Single sequences around the threshold
        for (int s = 0; s < 3; s++) begin
            send_sequence(5, 1'b1, 1'b0);
            idle_cycles(1);
            wait_for_results("single sequence");
        end

        // Back-to-back random lengths
        for (int s = 0; s < 10; s++) begin
            send_sequence(1 + int'(random_bits(3)), random_bits(1) == 32'd1, 1'b1);
        end
        idle_cycles(1);
        wait_for_results("back-to-back");

        // Output stalled until the input side backs up
        @(posedge ap_clk);
        request_ready <= 1'b0;
        fork
            begin
                for (int s = 0; s < 16; s++) begin
                    send_sequence(2 + int'(random_bits(2)), 1'b0, 1'b0);
                end
                idle_cycles(1);
            end
            begin
                wait_for_input_full();
                @(posedge ap_clk);
                request_ready <= 1'b1;
            end
        join
        wait_for_results("back-pressure");

        // Drained, so done stays up and nothing else leaves
        wait_for_done();
        repeat (20) begin
            @(negedge ap_clk);
            check_value("done after drain", 32'(done), 32'd1);
            check_value("input FIFO empty after drain",
                        32'(response_fifo_status.empty), 32'd1);
        end
        check_value("config_setup pulses", setup_pulses, 32'd1);
        check_value("result count", rx_count, expected.size());
        finish_run();
    end

endmodule : sieve_engine_tb

`default_nettype wire

// ==== verilog.f ====
verilog/sieve_pkg.sv
verilog/packet_fifo.sv
verilog/sieve_control_fsm.sv
verilog/sequence_hold_timer.sv
verilog/sieve_kernel.sv
verilog/result_pipeline.sv
verilog/sieve_engine_top.sv
sim/sieve_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module sieve_engine_tb \
    -f verilog.f \
    --Mdir obj_dir \
    -o sieve_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sieve_sim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# The run passes only if the testbench reported a pass
if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
